//--- src/mmio_params.svh
`ifndef MMIO_PARAMS_SVH
`define MMIO_PARAMS_SVH

// bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 64

// peripheral register widths
`define KB_WIDTH 8
`define SEG_WIDTH 32
`define LED_WIDTH 16

// data RAM window, 4 KiB
`define ADDR_RAM 32'h8000_0000
`define RAM_LEN 4096

// microsecond counter, one double word
`define RTC_ADDR 32'ha000_0048
`define RTC_LEN 8

// keyboard queue head, popped on read
`define KBD_ADDR 32'ha000_0060
`define KBD_LEN 4

// switch input, read only
`define SWT_ADDR 32'ha000_0070

// display and LED registers, write only
`define SEG_ADDR 32'ha000_0080
`define LED_ADDR 32'ha000_0090

// window size shared by switch, segment and LED registers
`define PERI_LEN 4

// scan codes held before the CPU drains them
`define KB_DEPTH 8

// core clock cycles per microsecond
`define RTC_DIV 50

`endif

//--- src/mmio_pkg.sv
`include "mmio_params.svh"

package mmio_pkg;

    // load/store port address
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // load/store port data, one double word
    typedef logic [`DATA_WIDTH-1:0] data_t;

    // keyboard scan code
    typedef logic [`KB_WIDTH-1:0] kb_code_t;

    // seven-segment display register
    typedef logic [`SEG_WIDTH-1:0] seg_t;

    // LED register
    typedef logic [`LED_WIDTH-1:0] led_t;

    // store width, as encoded by the CPU
    typedef enum logic [1:0] {
        WR_BYTE   = 2'd0,
        WR_HALF   = 2'd1,
        WR_WORD   = 2'd2,
        WR_DOUBLE = 2'd3
    } wr_width_e;

endpackage

//--- src/ram.sv
`timescale 1ns/1ps

`include "mmio_params.svh"

module ram (
    input  logic                clk,
    input  mmio_pkg::addr_t     mem_raddr,
    input  mmio_pkg::addr_t     mem_waddr,
    input  mmio_pkg::data_t     mem_wdata,
    input  logic                ram_wen,
    input  mmio_pkg::wr_width_e wr_width,
    output mmio_pkg::data_t     ram_rdata
);

    localparam int unsigned LANES     = `DATA_WIDTH / 8;
    localparam int unsigned OFF_W     = $clog2(LANES);
    localparam int unsigned RAM_AW    = $clog2(`RAM_LEN);
    localparam int unsigned RAM_WORDS = `RAM_LEN / LANES;
    localparam int unsigned IDX_W     = RAM_AW - OFF_W;

    mmio_pkg::data_t  mem [RAM_WORDS];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [OFF_W-1:0] off;
    logic [OFF_W-1:0] off_al;
    logic [LANES-1:0] lane_mask;
    logic [LANES-1:0] lane_en;
    mmio_pkg::data_t  wdata_sh;

    // base is 4 KiB aligned, so the low address bits are the offset
    assign rd_idx = mem_raddr[RAM_AW-1:OFF_W];
    assign wr_idx = mem_waddr[RAM_AW-1:OFF_W];
    assign off    = mem_waddr[OFF_W-1:0];

    // read ignores the byte offset
    assign ram_rdata = mem[rd_idx];

    // lane mask per width, offset rounded down to natural alignment
    always_comb begin
        off_al    = off;
        lane_mask = 8'b0000_0001;
        case (wr_width)
            mmio_pkg::WR_BYTE: begin
                off_al    = off;
                lane_mask = 8'b0000_0001;
            end
            mmio_pkg::WR_HALF: begin
                off_al    = {off[2:1], 1'b0};
                lane_mask = 8'b0000_0011;
            end
            mmio_pkg::WR_WORD: begin
                off_al    = {off[2], 2'b00};
                lane_mask = 8'b0000_1111;
            end
            mmio_pkg::WR_DOUBLE: begin
                off_al    = '0;
                lane_mask = 8'b1111_1111;
            end
            default: begin
                off_al    = off;
                lane_mask = 8'b0000_0001;
            end
        endcase
        lane_en  = lane_mask << off_al;
        // low bytes of the store data move up to the selected lanes
        wdata_sh = mem_wdata << {off_al, 3'b000};
    end

    always_ff @(posedge clk) begin
        if (ram_wen) begin
            for (int i = 0; i < LANES; i++) begin
                if (lane_en[i]) begin
                    mem[wr_idx][8*i +: 8] <= wdata_sh[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- src/kbd_fifo.sv
`timescale 1ns/1ps

`include "mmio_params.svh"

module kbd_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  mmio_pkg::kb_code_t kb_code,
    input  logic               kb_valid,
    input  logic               kb_pop,
    output mmio_pkg::kb_code_t kb_rdata,
    output logic               kb_ready
);

    localparam int unsigned PTR_W = $clog2(`KB_DEPTH);

    mmio_pkg::kb_code_t fifo_mem [`KB_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`KB_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == (PTR_W+1)'(`KB_DEPTH));
    assign kb_ready = (count != '0);

    // codes arriving while full are lost
    assign push = kb_valid && !full;
    assign pop  = kb_pop && kb_ready;

    // head is always visible to the decoder
    assign kb_rdata = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= kb_code;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- src/rtc_counter.sv
`timescale 1ns/1ps

`include "mmio_params.svh"

module rtc_counter (
    input  logic            clk,
    input  logic            rst_n,
    output mmio_pkg::data_t rtc_count
);

    localparam int unsigned DIV_W = $clog2(`RTC_DIV);

    logic [DIV_W-1:0] presc;
    logic             tick;

    // one microsecond elapsed
    assign tick = (presc == DIV_W'(`RTC_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc <= '0;
        end else if (tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // free running, wraps after 2^64 microseconds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rtc_count <= '0;
        end else if (tick) begin
            rtc_count <= rtc_count + 1'b1;
        end
    end

endmodule

//--- src/mmio.sv
`timescale 1ns/1ps

`include "mmio_params.svh"

module mmio (
    input  logic               clk,
    input  logic               rst_n,
    input  mmio_pkg::addr_t    mem_raddr,
    input  logic               mem_ren,
    input  mmio_pkg::addr_t    mem_waddr,
    input  mmio_pkg::data_t    mem_wdata,
    input  logic               mem_wen,
    input  mmio_pkg::data_t    ram_rdata,
    input  mmio_pkg::kb_code_t kb_rdata,
    input  logic               kb_ready,
    input  logic [7:0]         swt,
    input  mmio_pkg::data_t    rtc_count,
    output mmio_pkg::data_t    mem_rdata,
    output logic               ram_wen,
    output logic               kb_pop,
    output logic               bus_err,
    output mmio_pkg::seg_t     seg_out,
    output mmio_pkg::led_t     led_out
);

    logic rd_ram;
    logic rd_kbd;
    logic rd_swt;
    logic rd_rtc;
    logic wr_ram;
    logic wr_seg;
    logic wr_led;

    function automatic logic in_win(input mmio_pkg::addr_t a,
                                    input mmio_pkg::addr_t base,
                                    input int unsigned     len);
        // subtract first so base + len never overflows
        return (a >= base) && ((a - base) < len);
    endfunction

    // true for any address that some device claims
    function automatic logic in_map(input mmio_pkg::addr_t a);
        return in_win(a, `ADDR_RAM, `RAM_LEN)
            || in_win(a, `RTC_ADDR, `RTC_LEN)
            || in_win(a, `KBD_ADDR, `KBD_LEN)
            || in_win(a, `SWT_ADDR, `PERI_LEN)
            || in_win(a, `SEG_ADDR, `PERI_LEN)
            || in_win(a, `LED_ADDR, `PERI_LEN);
    endfunction

    // read side decode
    assign rd_ram = in_win(mem_raddr, `ADDR_RAM, `RAM_LEN);
    assign rd_kbd = in_win(mem_raddr, `KBD_ADDR, `KBD_LEN);
    assign rd_swt = in_win(mem_raddr, `SWT_ADDR, `PERI_LEN);
    assign rd_rtc = in_win(mem_raddr, `RTC_ADDR, `RTC_LEN);

    // write side decode
    assign wr_ram = in_win(mem_waddr, `ADDR_RAM, `RAM_LEN);
    assign wr_seg = in_win(mem_waddr, `SEG_ADDR, `PERI_LEN);
    assign wr_led = in_win(mem_waddr, `LED_ADDR, `PERI_LEN);

    assign ram_wen = mem_wen && wr_ram;

    assign bus_err = (mem_ren && !in_map(mem_raddr))
                  || (mem_wen && !in_map(mem_waddr));

    // segment and LED windows read back as zero
    always_comb begin
        mem_rdata = '0;
        kb_pop    = 1'b0;
        if (mem_ren) begin
            if (rd_ram) begin
                mem_rdata = ram_rdata;
            end else if (rd_kbd) begin
                // empty queue reads zero and is left alone
                if (kb_ready) begin
                    kb_pop    = 1'b1;
                    mem_rdata = {{(`DATA_WIDTH - `KB_WIDTH){1'b0}}, kb_rdata};
                end
            end else if (rd_swt) begin
                mem_rdata = {{(`DATA_WIDTH - 8){1'b0}}, swt};
            end else if (rd_rtc) begin
                mem_rdata = rtc_count;
            end
        end
    end

    // display outputs hold until the CPU stores again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_out <= '0;
            led_out <= '0;
        end else if (mem_wen) begin
            if (wr_seg) begin
                seg_out <= mem_wdata[`SEG_WIDTH-1:0];
            end
            if (wr_led) begin
                led_out <= mem_wdata[`LED_WIDTH-1:0];
            end
        end
    end

endmodule

//--- src/mmio_top.sv
`timescale 1ns/1ps

module mmio_top (
    input  logic                clk,
    input  logic                rst_n,
    input  mmio_pkg::addr_t     mem_raddr,
    input  logic                mem_ren,
    input  mmio_pkg::addr_t     mem_waddr,
    input  mmio_pkg::data_t     mem_wdata,
    input  logic                mem_wen,
    input  mmio_pkg::wr_width_e wr_width,
    input  mmio_pkg::kb_code_t  kb_code,
    input  logic                kb_valid,
    input  logic [7:0]          swt,
    output mmio_pkg::data_t     mem_rdata,
    output logic                bus_err,
    output mmio_pkg::seg_t      seg_out,
    output mmio_pkg::led_t      led_out
);

    logic               ram_wen;
    mmio_pkg::data_t    ram_rdata;
    mmio_pkg::kb_code_t kb_rdata;
    logic               kb_ready;
    logic               kb_pop;
    mmio_pkg::data_t    rtc_count;

    mmio u_mmio (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_raddr (mem_raddr),
        .mem_ren   (mem_ren),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wen   (mem_wen),
        .ram_rdata (ram_rdata),
        .kb_rdata  (kb_rdata),
        .kb_ready  (kb_ready),
        .swt       (swt),
        .rtc_count (rtc_count),
        .mem_rdata (mem_rdata),
        .ram_wen   (ram_wen),
        .kb_pop    (kb_pop),
        .bus_err   (bus_err),
        .seg_out   (seg_out),
        .led_out   (led_out)
    );

    // width goes straight to the RAM lane logic
    ram u_ram (
        .clk       (clk),
        .mem_raddr (mem_raddr),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .ram_wen   (ram_wen),
        .wr_width  (wr_width),
        .ram_rdata (ram_rdata)
    );

    kbd_fifo u_kbd_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .kb_code  (kb_code),
        .kb_valid (kb_valid),
        .kb_pop   (kb_pop),
        .kb_rdata (kb_rdata),
        .kb_ready (kb_ready)
    );

    rtc_counter u_rtc_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .rtc_count (rtc_count)
    );

endmodule

//--- tests/mmio_assert.sv
`timescale 1ns/1ps

`include "mmio_params.svh"

module mmio_assert (
    input logic            clk,
    input logic            rst_n,
    input mmio_pkg::addr_t mem_raddr,
    input logic            mem_ren,
    input mmio_pkg::addr_t mem_waddr,
    input logic            kb_pop,
    input logic            kb_ready,
    input logic            ram_wen,
    input logic            mem_wen,
    input logic            bus_err
);

    // assertion failures seen so far
    int unsigned fail_count = 0;

    logic rd_kbd_win;
    logic wr_ram_win;

    // windows are aligned to their size, masking the offset gives the base
    assign rd_kbd_win = ((mem_raddr & ~32'(`KBD_LEN - 1)) == `KBD_ADDR);
    assign wr_ram_win = ((mem_waddr & ~32'(`RAM_LEN - 1)) == `ADDR_RAM);

    // pop only for a keyboard read while the queue holds a code
    pop_needs_code: assert property (@(posedge clk) disable iff (!rst_n)
        kb_pop |-> kb_ready && mem_ren && rd_kbd_win)
        else begin
            fail_count++;
            $error("keyboard pop issued without a keyboard read of a non-empty queue");
        end

    ram_wen_needs_wen: assert property (@(posedge clk) disable iff (!rst_n)
        ram_wen |-> mem_wen && wr_ram_win)
        else begin
            fail_count++;
            $error("RAM write enable without a bus write to the RAM window");
        end

    // an in-range RAM write is never an error
    no_err_on_ram_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_err && ram_wen))
        else begin
            fail_count++;
            $error("bus error raised together with a RAM write");
        end

endmodule

bind mmio mmio_assert i_mmio_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_raddr (mem_raddr),
    .mem_ren   (mem_ren),
    .mem_waddr (mem_waddr),
    .kb_pop    (kb_pop),
    .kb_ready  (kb_ready),
    .ram_wen   (ram_wen),
    .mem_wen   (mem_wen),
    .bus_err   (bus_err)
);

//--- tests/mmio_tb.sv
`timescale 1ns/1ps

`include "mmio_params.svh"

module mmio_tb;

    localparam int unsigned RAM_WORDS    = `RAM_LEN / 8;
    localparam int unsigned COUNT_GAP    = 137;
    localparam int unsigned TICK_TIMEOUT = 3 * `RTC_DIV;

    logic                clk;
    logic                rst_n;
    mmio_pkg::addr_t     mem_raddr;
    logic                mem_ren;
    mmio_pkg::addr_t     mem_waddr;
    mmio_pkg::data_t     mem_wdata;
    logic                mem_wen;
    mmio_pkg::wr_width_e wr_width;
    mmio_pkg::kb_code_t  kb_code;
    logic                kb_valid;
    logic [7:0]          swt;
    mmio_pkg::data_t     mem_rdata;
    logic                bus_err;
    mmio_pkg::seg_t      seg_out;
    mmio_pkg::led_t      led_out;

    // expected values, one set per stimulus cycle
    logic            exp_on;
    logic            exp_data_on;
    mmio_pkg::data_t exp_data;
    logic            exp_err;
    mmio_pkg::seg_t  exp_seg;
    mmio_pkg::led_t  exp_led;

    // reference model state
    mmio_pkg::data_t    ram_shadow [RAM_WORDS];
    mmio_pkg::kb_code_t kb_model [$];
    mmio_pkg::seg_t     seg_model;
    mmio_pkg::led_t     led_model;
    logic [7:0]         swt_level;
    logic [31:0]        lcg_state;

    mmio_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_raddr (mem_raddr),
        .mem_ren   (mem_ren),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wen   (mem_wen),
        .wr_width  (wr_width),
        .kb_code   (kb_code),
        .kb_valid  (kb_valid),
        .swt       (swt),
        .mem_rdata (mem_rdata),
        .bus_err   (bus_err),
        .seg_out   (seg_out),
        .led_out   (led_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED time=%0t %s expected=%h actual=%h",
                     $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic in_range(input mmio_pkg::addr_t a, input logic [32:0] base,
                                      input int unsigned len);
        logic [32:0] wide;
        wide = {1'b0, a};
        return (wide >= base) && (wide < base + 33'(len));
    endfunction

    function automatic logic mapped(input mmio_pkg::addr_t a);
        return in_range(a, `ADDR_RAM, `RAM_LEN) || in_range(a, `RTC_ADDR, `RTC_LEN)
            || in_range(a, `KBD_ADDR, `KBD_LEN) || in_range(a, `SWT_ADDR, `PERI_LEN)
            || in_range(a, `SEG_ADDR, `PERI_LEN) || in_range(a, `LED_ADDR, `PERI_LEN);
    endfunction

    // store of 1, 2, 4 or 8 bytes at a naturally aligned offset
    function automatic mmio_pkg::data_t merge_lanes(input mmio_pkg::data_t old,
                                                    input mmio_pkg::data_t wdata,
                                                    input int off,
                                                    input mmio_pkg::wr_width_e width);
        int              nbytes;
        int              base;
        mmio_pkg::data_t res;
        nbytes = 1 << int'(width);
        base   = off - (off % nbytes);
        res    = old;
        for (int i = 0; i < nbytes; i++) begin
            res[8*(base+i) +: 8] = wdata[8*i +: 8];
        end
        return res;
    endfunction

    function automatic mmio_pkg::data_t expected_read(input logic ren,
                                                      input mmio_pkg::addr_t a);
        if (!ren) begin
            return '0;
        end
        if (in_range(a, `ADDR_RAM, `RAM_LEN)) begin
            return ram_shadow[(a - `ADDR_RAM) >> 3];
        end
        if (in_range(a, `KBD_ADDR, `KBD_LEN)) begin
            return (kb_model.size() > 0) ? mmio_pkg::data_t'(kb_model[0]) : '0;
        end
        if (in_range(a, `SWT_ADDR, `PERI_LEN)) begin
            return mmio_pkg::data_t'(swt_level);
        end
        // counter value is checked by range, everything else reads zero
        return '0;
    endfunction

    function automatic logic expected_err(input logic ren, input mmio_pkg::addr_t raddr,
                                          input logic wen, input mmio_pkg::addr_t waddr);
        return (ren && !mapped(raddr)) || (wen && !mapped(waddr));
    endfunction

    // model state after the edge that ends this cycle
    function automatic void apply_access(input logic ren, input mmio_pkg::addr_t raddr,
                                         input logic wen, input mmio_pkg::addr_t waddr,
                                         input mmio_pkg::data_t wdata,
                                         input mmio_pkg::wr_width_e width,
                                         input logic kvalid, input mmio_pkg::kb_code_t kcode);
        logic full;
        int   idx;
        full = (kb_model.size() == `KB_DEPTH);
        if (ren && in_range(raddr, `KBD_ADDR, `KBD_LEN) && kb_model.size() > 0) begin
            void'(kb_model.pop_front());
        end
        if (kvalid && !full) begin
            kb_model.push_back(kcode);
        end
        if (wen && in_range(waddr, `ADDR_RAM, `RAM_LEN)) begin
            idx = int'((waddr - `ADDR_RAM) >> 3);
            ram_shadow[idx] = merge_lanes(ram_shadow[idx], wdata, int'(waddr[2:0]), width);
        end
        if (wen && in_range(waddr, `SEG_ADDR, `PERI_LEN)) begin
            seg_model = wdata[`SEG_WIDTH-1:0];
        end
        if (wen && in_range(waddr, `LED_ADDR, `PERI_LEN)) begin
            led_model = wdata[`LED_WIDTH-1:0];
        end
    endfunction

    task automatic bus_cycle(input logic ren, input mmio_pkg::addr_t raddr,
                             input logic wen, input mmio_pkg::addr_t waddr,
                             input mmio_pkg::data_t wdata, input mmio_pkg::wr_width_e width,
                             input logic kvalid, input mmio_pkg::kb_code_t kcode,
                             input logic data_known);
        @(posedge clk);
        mem_ren     <= ren;
        mem_raddr   <= raddr;
        mem_wen     <= wen;
        mem_waddr   <= waddr;
        mem_wdata   <= wdata;
        wr_width    <= width;
        kb_valid    <= kvalid;
        kb_code     <= kcode;
        swt         <= swt_level;
        exp_on      <= 1'b1;
        exp_data_on <= data_known;
        exp_data    <= expected_read(ren, raddr);
        exp_err     <= expected_err(ren, raddr, wen, waddr);
        // registers seen now hold writes issued in earlier cycles
        exp_seg     <= seg_model;
        exp_led     <= led_model;
        apply_access(ren, raddr, wen, waddr, wdata, width, kvalid, kcode);
    endtask

    task automatic do_read(input mmio_pkg::addr_t a);
        bus_cycle(1'b1, a, 1'b0, '0, '0, mmio_pkg::WR_BYTE, 1'b0, '0, 1'b1);
    endtask

    task automatic do_write(input mmio_pkg::addr_t a, input mmio_pkg::data_t d,
                            input mmio_pkg::wr_width_e w);
        bus_cycle(1'b0, '0, 1'b1, a, d, w, 1'b0, '0, 1'b1);
    endtask

    task automatic push_code(input mmio_pkg::kb_code_t c);
        bus_cycle(1'b0, '0, 1'b0, '0, '0, mmio_pkg::WR_BYTE, 1'b1, c, 1'b1);
    endtask

    task automatic idle_cycles(input int unsigned n);
        repeat (n) begin
            bus_cycle(1'b0, '0, 1'b0, '0, '0, mmio_pkg::WR_BYTE, 1'b0, '0, 1'b1);
        end
    endtask

    task automatic read_counter(output mmio_pkg::data_t value);
        bus_cycle(1'b1, `RTC_ADDR, 1'b0, '0, '0, mmio_pkg::WR_BYTE, 1'b0, '0, 1'b0);
        @(negedge clk);
        value = mem_rdata;
    endtask

    // fill pattern built from the whole address
    task automatic preload_ram();
        mmio_pkg::addr_t a;
        for (int w = 0; w < RAM_WORDS; w++) begin
            a = `ADDR_RAM + 32'(w * 8);
            do_write(a, {a ^ 32'h5a5a_0f0f, ~a}, mmio_pkg::WR_DOUBLE);
        end
    endtask

    task automatic ram_traffic(input int unsigned n);
        logic [31:0]         r;
        mmio_pkg::addr_t     a;
        mmio_pkg::wr_width_e w;
        for (int i = 0; i < n; i++) begin
            r = lcg_next();
            a = `ADDR_RAM + 32'(r[27:16]);
            w = mmio_pkg::wr_width_e'(r[31:30]);
            do_write(a, {lcg_next(), lcg_next()}, w);
            // low address bits select nothing on a read
            do_read(a);
        end
    endtask

    task automatic keyboard_test();
        for (int i = 0; i < 3; i++) begin
            push_code(8'h1c + 8'(i));
        end
        idle_cycles(1);
        repeat (4) do_read(`KBD_ADDR);
        // overflow, the last three codes are lost
        for (int i = 0; i < `KB_DEPTH + 3; i++) begin
            push_code(8'h40 + 8'(i));
        end
        idle_cycles(1);
        repeat (`KB_DEPTH + 1) do_read(`KBD_ADDR);
        // push and pop in the same cycle
        push_code(8'h77);
        bus_cycle(1'b1, `KBD_ADDR, 1'b0, '0, '0, mmio_pkg::WR_BYTE, 1'b1, 8'h78, 1'b1);
        repeat (2) do_read(`KBD_ADDR + 32'd2);
    endtask

    task automatic counter_test();
        mmio_pkg::data_t first;
        mmio_pkg::data_t now_val;
        mmio_pkg::data_t diff;
        int unsigned     waited;
        int unsigned     lo;
        read_counter(first);
        now_val = first;
        waited  = 0;
        while (now_val == first) begin
            if (waited >= TICK_TIMEOUT) begin
                $display("timeout: the microsecond counter did not advance in %0d cycles",
                         TICK_TIMEOUT);
                $display(">>> FAIL");
                $fatal(1, "counter stalled");
            end
            read_counter(now_val);
            waited++;
        end
        check_value("rtc_step", first + 1, now_val);
        read_counter(first);
        idle_cycles(COUNT_GAP - 1);
        read_counter(now_val);
        diff = now_val - first;
        lo   = COUNT_GAP / `RTC_DIV;
        if (diff != 64'(lo)) begin
            check_value("rtc_delta", 64'(lo + 1), diff);
        end
    endtask

    task automatic error_test();
        mmio_pkg::addr_t ra;
        mmio_pkg::addr_t wa;
        do_read(32'h1234_5678);
        do_write(32'ha000_0050, {lcg_next(), lcg_next()}, mmio_pkg::WR_DOUBLE);
        do_write(`ADDR_RAM + `RAM_LEN, {lcg_next(), lcg_next()}, mmio_pkg::WR_DOUBLE);
        do_write(`LED_ADDR + `PERI_LEN, {lcg_next(), lcg_next()}, mmio_pkg::WR_WORD);
        do_read(`SEG_ADDR + `PERI_LEN);
        do_read(`ADDR_RAM);
        for (int i = 0; i < 16; i++) begin
            ra = lcg_next();
            wa = lcg_next();
            bus_cycle(1'b1, ra, 1'b1, wa, {lcg_next(), lcg_next()}, mmio_pkg::WR_DOUBLE,
                      1'b0, '0, !in_range(ra, `RTC_ADDR, `RTC_LEN));
        end
    endtask

    // compare process, outputs settle well before the falling edge
    always @(negedge clk) begin
        if (exp_on) begin
            if (exp_data_on) begin
                check_value("mem_rdata", exp_data, mem_rdata);
            end
            check_value("bus_err", exp_err, bus_err);
            check_value("seg_out", exp_seg, seg_out);
            check_value("led_out", exp_led, led_out);
        end
    end

    initial begin
        lcg_state   = 32'h985a;
        rst_n       = 1'b0;
        mem_raddr   = '0;
        mem_ren     = 1'b0;
        mem_waddr   = '0;
        mem_wdata   = '0;
        mem_wen     = 1'b0;
        wr_width    = mmio_pkg::WR_BYTE;
        kb_code     = '0;
        kb_valid    = 1'b0;
        swt         = '0;
        swt_level   = '0;
        exp_on      = 1'b0;
        exp_data_on = 1'b0;
        exp_data    = '0;
        exp_err     = 1'b0;
        exp_seg     = '0;
        exp_led     = '0;
        seg_model   = '0;
        led_model   = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // disabled read of a RAM address still returns zero
        bus_cycle(1'b0, `ADDR_RAM, 1'b0, '0, '0, mmio_pkg::WR_BYTE, 1'b0, '0, 1'b1);
        preload_ram();
        ram_traffic(200);

        do_write(`SEG_ADDR, {lcg_next(), lcg_next()}, mmio_pkg::WR_WORD);
        do_write(`LED_ADDR + 32'd2, {lcg_next(), lcg_next()}, mmio_pkg::WR_HALF);
        do_write(`ADDR_RAM + 32'd16, {lcg_next(), lcg_next()}, mmio_pkg::WR_DOUBLE);
        idle_cycles(2);

        keyboard_test();

        swt_level = 8'ha5;
        do_read(`SWT_ADDR);
        swt_level = 8'h3c;
        do_read(`SWT_ADDR + 32'd3);
        counter_test();

        error_test();
        idle_cycles(2);
        @(posedge clk);
        exp_on <= 1'b0;
        @(posedge clk);
        if (i_dut.u_mmio.i_mmio_assert.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("%0d assertion failures on the decoder",
                     i_dut.u_mmio.i_mmio_assert.fail_count);
            $display(">>> FAIL");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- src.f
+incdir+src
src/mmio_pkg.sv
src/ram.sv
src/kbd_fifo.sv
src/rtc_counter.sv
src/mmio.sv
src/mmio_top.sv
tests/mmio_assert.sv
tests/mmio_tb.sv
